//--- list.f
+incdir+verification
rtl/axil_pkg.sv
rtl/gen_regs_pkg.sv
rtl/axil_slave_fsm.sv
rtl/gen_reg_file.sv
rtl/traffic_gen_cfg_top.sv
verification/tb_traffic_gen_cfg.sv

//--- rtl/axil_pkg.sv
//////////////////////////////
// axi4-lite bus definitions
// widths, response codes, slave FSM states
// and the register request structs
//////////////////////////////
`default_nettype none

package axil_pkg;

    // byte address covers sixteen 32-bit words
    localparam int unsigned AXIL_ADDR_W = 6;
    localparam int unsigned AXIL_DATA_W = 32;
    localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    // five states, so three bits
    typedef enum logic [2:0] {
        IDLE,
        WR_ACCEPT,
        WR_RESP,
        RD_ACCEPT,
        RD_DATA
    } axil_state_e;

    // write request to the register file, 43 bits
    typedef struct packed {
        logic                   en;
        logic [AXIL_ADDR_W-1:0] addr;
        logic [AXIL_DATA_W-1:0] data;
        logic [AXIL_STRB_W-1:0] strb;
    } reg_wr_req_t;

    // read request to the register file, 7 bits
    typedef struct packed {
        logic                   en;
        logic [AXIL_ADDR_W-1:0] addr;
    } reg_rd_req_t;

endpackage

`default_nettype wire

//--- rtl/axil_slave_fsm.sv
//////////////////////////////
// axi4-lite slave FSM
// turns bus transfers into single-cycle
// register write and read requests
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module axil_slave_fsm (
    input  wire                               clk,
    input  wire                               reset_n,

    // write address and data
    input  wire  [axil_pkg::AXIL_ADDR_W-1:0]  axil_awaddr_i,
    input  wire                               axil_awvalid_i,
    output logic                              axil_awready_o,
    input  wire  [axil_pkg::AXIL_DATA_W-1:0]  axil_wdata_i,
    input  wire  [axil_pkg::AXIL_STRB_W-1:0]  axil_wstrb_i,
    input  wire                               axil_wvalid_i,
    output logic                              axil_wready_o,

    // write response
    output logic                              axil_bvalid_o,
    output axil_pkg::axil_resp_e              axil_bresp_o,
    input  wire                               axil_bready_i,

    // read address and data
    input  wire  [axil_pkg::AXIL_ADDR_W-1:0]  axil_araddr_i,
    input  wire                               axil_arvalid_i,
    output logic                              axil_arready_o,
    output logic                              axil_rvalid_o,
    output logic [axil_pkg::AXIL_DATA_W-1:0]  axil_rdata_o,
    output axil_pkg::axil_resp_e              axil_rresp_o,
    input  wire                               axil_rready_i,

    // register file side
    output axil_pkg::reg_wr_req_t             wr_req_o,
    output axil_pkg::reg_rd_req_t             rd_req_o,
    input  wire  [axil_pkg::AXIL_DATA_W-1:0]  rd_data_i
);

    import axil_pkg::*;

    axil_state_e state_q;
    axil_state_e state_d;

    logic        wr_pending;

    // a write needs both address and data before it starts
    assign wr_pending = axil_awvalid_i && axil_wvalid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // writes win over a read waiting at the same time
                if (wr_pending) begin
                    state_d = WR_ACCEPT;
                end else if (axil_arvalid_i) begin
                    state_d = RD_ACCEPT;
                end
            end
            WR_ACCEPT: begin
                state_d = WR_RESP;
            end
            WR_RESP: begin
                if (axil_bready_i) begin
                    state_d = IDLE;
                end
            end
            RD_ACCEPT: begin
                state_d = RD_DATA;
            end
            RD_DATA: begin
                if (axil_rready_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // handshake outputs straight from the state
    assign axil_awready_o = (state_q == WR_ACCEPT);
    assign axil_wready_o  = (state_q == WR_ACCEPT);
    assign axil_bvalid_o  = (state_q == WR_RESP);
    assign axil_arready_o = (state_q == RD_ACCEPT);
    assign axil_rvalid_o  = (state_q == RD_DATA);

    // no error cases in this map
    assign axil_bresp_o = OKAY;
    assign axil_rresp_o = OKAY;

    // request is live during the accept cycle, master still holds the payload
    assign wr_req_o.en   = (state_q == WR_ACCEPT);
    assign wr_req_o.addr = axil_awaddr_i;
    assign wr_req_o.data = axil_wdata_i;
    assign wr_req_o.strb = axil_wstrb_i;

    assign rd_req_o.en   = (state_q == RD_ACCEPT);
    assign rd_req_o.addr = axil_araddr_i;

    // read register in the file loads only on a request,
    // so rdata stays put for as long as RD_DATA waits on rready
    assign axil_rdata_o = rd_data_i;

endmodule

`default_nettype wire

//--- rtl/gen_reg_file.sv
//////////////////////////////
// traffic generator register file
// byte-strobe writes, start/stop pulses,
// registered read multiplexer
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module gen_reg_file #(
    parameter int unsigned CHANNEL_WIDTH = 10
) (
    input  wire                               clk,
    input  wire                               reset_n,

    input  wire  axil_pkg::reg_wr_req_t       wr_req_i,
    input  wire  axil_pkg::reg_rd_req_t       rd_req_i,
    output logic [axil_pkg::AXIL_DATA_W-1:0]  rd_data_o,

    output logic                              start_o,
    output logic                              stop_o,
    output gen_regs_pkg::gen_cfg_t            cfg_o,
    output logic [CHANNEL_WIDTH-1:0]          fixed_channel_o,
    output logic [CHANNEL_WIDTH-1:0]          min_channel_o,
    output logic [CHANNEL_WIDTH-1:0]          max_channel_o
);

    import axil_pkg::*;
    import gen_regs_pkg::*;

    reg_index_e                 wr_idx;
    reg_index_e                 rd_idx;
    logic                       ctrl_wr;
    logic [AXIL_DATA_W-1:0]     rd_mux;

    gen_cfg_t                   cfg_q;
    logic [CHANNEL_WIDTH-1:0]   fixed_channel_q;
    logic [CHANNEL_WIDTH-1:0]   min_channel_q;
    logic [CHANNEL_WIDTH-1:0]   max_channel_q;

    // old value with the strobed bytes of the request laid over it
    function automatic logic [AXIL_DATA_W-1:0] strb_merge(
        input logic [AXIL_DATA_W-1:0] old_val,
        input reg_wr_req_t            req
    );
        logic [AXIL_DATA_W-1:0] result;
        result = old_val;
        for (int i = 0; i < AXIL_STRB_W; i++) begin
            if (req.strb[i]) begin
                result[8*i +: 8] = req.data[8*i +: 8];
            end
        end
        return result;
    endfunction

    // word index, upper address bits only
    assign wr_idx = reg_index_e'(wr_req_i.addr[AXIL_ADDR_W-1:2]);
    assign rd_idx = reg_index_e'(rd_req_i.addr[AXIL_ADDR_W-1:2]);

    // all control bits sit in byte 0
    assign ctrl_wr = wr_req_i.en && (wr_idx == CONTROL) && wr_req_i.strb[0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_q           <= '0;
            fixed_channel_q <= '0;
            min_channel_q   <= '0;
            max_channel_q   <= '0;
        end else if (wr_req_i.en) begin
            case (wr_idx)
                CONTROL: begin
                    if (ctrl_wr) begin
                        cfg_q.mode.auto_length  <= wr_req_i.data[CTRL_AUTO_LENGTH_BIT];
                        cfg_q.mode.auto_channel <= wr_req_i.data[CTRL_AUTO_CHANNEL_BIT];
                        cfg_q.mode.auto_pause   <= wr_req_i.data[CTRL_AUTO_PAUSE_BIT];
                        cfg_q.mode.use_limit_transaction <= wr_req_i.data[CTRL_USE_LIMIT_BIT];
                    end
                end
                FIXED_LENGTH: cfg_q.fixed_length <= LENGTH_W'(
                    strb_merge(AXIL_DATA_W'(cfg_q.fixed_length), wr_req_i));
                MIN_LENGTH: cfg_q.min_length <= LENGTH_W'(
                    strb_merge(AXIL_DATA_W'(cfg_q.min_length), wr_req_i));
                MAX_LENGTH: cfg_q.max_length <= LENGTH_W'(
                    strb_merge(AXIL_DATA_W'(cfg_q.max_length), wr_req_i));
                // only the low CHANNEL_WIDTH bits are kept
                FIXED_CHANNEL: fixed_channel_q <= CHANNEL_WIDTH'(
                    strb_merge(AXIL_DATA_W'(fixed_channel_q), wr_req_i));
                MIN_CHANNEL: min_channel_q <= CHANNEL_WIDTH'(
                    strb_merge(AXIL_DATA_W'(min_channel_q), wr_req_i));
                MAX_CHANNEL: max_channel_q <= CHANNEL_WIDTH'(
                    strb_merge(AXIL_DATA_W'(max_channel_q), wr_req_i));
                FIXED_PAUSE: cfg_q.fixed_pause <= PAUSE_W'(
                    strb_merge(AXIL_DATA_W'(cfg_q.fixed_pause), wr_req_i));
                MIN_PAUSE: cfg_q.min_pause <= PAUSE_W'(
                    strb_merge(AXIL_DATA_W'(cfg_q.min_pause), wr_req_i));
                MAX_PAUSE: cfg_q.max_pause <= PAUSE_W'(
                    strb_merge(AXIL_DATA_W'(cfg_q.max_pause), wr_req_i));
                CNT_PACKET: cfg_q.cnt_packet <= strb_merge(cfg_q.cnt_packet, wr_req_i);
                // unmapped words, write dropped
                default: ;
            endcase
        end
    end

    // self-clearing, high for the cycle after the write edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_o <= 1'b0;
            stop_o  <= 1'b0;
        end else begin
            start_o <= ctrl_wr && wr_req_i.data[CTRL_START_BIT];
            stop_o  <= ctrl_wr && wr_req_i.data[CTRL_STOP_BIT];
        end
    end

    always_comb begin
        rd_mux = '0;
        case (rd_idx)
            CONTROL: begin
                rd_mux[CTRL_AUTO_LENGTH_BIT]  = cfg_q.mode.auto_length;
                rd_mux[CTRL_AUTO_CHANNEL_BIT] = cfg_q.mode.auto_channel;
                rd_mux[CTRL_AUTO_PAUSE_BIT]   = cfg_q.mode.auto_pause;
                rd_mux[CTRL_USE_LIMIT_BIT]    = cfg_q.mode.use_limit_transaction;
            end
            FIXED_LENGTH:  rd_mux = AXIL_DATA_W'(cfg_q.fixed_length);
            MIN_LENGTH:    rd_mux = AXIL_DATA_W'(cfg_q.min_length);
            MAX_LENGTH:    rd_mux = AXIL_DATA_W'(cfg_q.max_length);
            FIXED_CHANNEL: rd_mux = AXIL_DATA_W'(fixed_channel_q);
            MIN_CHANNEL:   rd_mux = AXIL_DATA_W'(min_channel_q);
            MAX_CHANNEL:   rd_mux = AXIL_DATA_W'(max_channel_q);
            FIXED_PAUSE:   rd_mux = AXIL_DATA_W'(cfg_q.fixed_pause);
            MIN_PAUSE:     rd_mux = AXIL_DATA_W'(cfg_q.min_pause);
            MAX_PAUSE:     rd_mux = AXIL_DATA_W'(cfg_q.max_pause);
            CNT_PACKET:    rd_mux = cfg_q.cnt_packet;
            default:       rd_mux = '0;
        endcase
    end

    // loads only on a read request and holds through the response
    always_ff @(posedge clk) begin
        if (rd_req_i.en) begin
            rd_data_o <= rd_mux;
        end
    end

    assign cfg_o           = cfg_q;
    assign fixed_channel_o = fixed_channel_q;
    assign min_channel_o   = min_channel_q;
    assign max_channel_o   = max_channel_q;

endmodule

`default_nettype wire

//--- rtl/gen_regs_pkg.sv
//////////////////////////////
// traffic generator register map
// word indexes, control bits, field widths
// and the configuration struct
//////////////////////////////
`default_nettype none

package gen_regs_pkg;

    // word index, taken from address bits 5:2
    typedef enum logic [3:0] {
        CONTROL       = 4'd0,
        FIXED_LENGTH  = 4'd1,
        MIN_LENGTH    = 4'd2,
        MAX_LENGTH    = 4'd3,
        FIXED_CHANNEL = 4'd4,
        MIN_CHANNEL   = 4'd5,
        MAX_CHANNEL   = 4'd6,
        FIXED_PAUSE   = 4'd7,
        MIN_PAUSE     = 4'd8,
        MAX_PAUSE     = 4'd9,
        CNT_PACKET    = 4'd10
    } reg_index_e;

    localparam int unsigned LENGTH_W = 16;
    localparam int unsigned PAUSE_W  = 32;

    // control register layout
    // bits 0 and 1 are pulses and read back as zero
    localparam int unsigned CTRL_START_BIT        = 0;
    localparam int unsigned CTRL_STOP_BIT         = 1;
    localparam int unsigned CTRL_AUTO_LENGTH_BIT  = 2;
    localparam int unsigned CTRL_AUTO_CHANNEL_BIT = 3;
    localparam int unsigned CTRL_AUTO_PAUSE_BIT   = 4;
    localparam int unsigned CTRL_USE_LIMIT_BIT    = 5;

    // mode bits kept from the control register
    typedef struct packed {
        logic auto_length;
        logic auto_channel;
        logic auto_pause;
        logic use_limit_transaction;
    } gen_mode_t;

    // everything except the channels, 180 bits
    typedef struct packed {
        gen_mode_t           mode;
        logic [LENGTH_W-1:0] fixed_length;
        logic [LENGTH_W-1:0] min_length;
        logic [LENGTH_W-1:0] max_length;
        logic [PAUSE_W-1:0]  fixed_pause;
        logic [PAUSE_W-1:0]  min_pause;
        logic [PAUSE_W-1:0]  max_pause;
        logic [31:0]         cnt_packet;
    } gen_cfg_t;

endpackage

`default_nettype wire

//--- rtl/traffic_gen_cfg_top.sv
//////////////////////////////
// traffic generator config block
// axi4-lite slave in front of the
// generator register file
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module traffic_gen_cfg_top #(
    parameter int unsigned CHANNEL_WIDTH = 10
) (
    input  wire                               clk,
    input  wire                               reset_n,

    // axi4-lite slave port
    input  wire  [axil_pkg::AXIL_ADDR_W-1:0]  axil_awaddr_i,
    input  wire                               axil_awvalid_i,
    output logic                              axil_awready_o,
    input  wire  [axil_pkg::AXIL_DATA_W-1:0]  axil_wdata_i,
    input  wire  [axil_pkg::AXIL_STRB_W-1:0]  axil_wstrb_i,
    input  wire                               axil_wvalid_i,
    output logic                              axil_wready_o,
    output logic                              axil_bvalid_o,
    output axil_pkg::axil_resp_e              axil_bresp_o,
    input  wire                               axil_bready_i,
    input  wire  [axil_pkg::AXIL_ADDR_W-1:0]  axil_araddr_i,
    input  wire                               axil_arvalid_i,
    output logic                              axil_arready_o,
    output logic                              axil_rvalid_o,
    output logic [axil_pkg::AXIL_DATA_W-1:0]  axil_rdata_o,
    output axil_pkg::axil_resp_e              axil_rresp_o,
    input  wire                               axil_rready_i,

    // generator settings
    output logic                              start_o,
    output logic                              stop_o,
    output gen_regs_pkg::gen_cfg_t            cfg_o,
    output logic [CHANNEL_WIDTH-1:0]          fixed_channel_o,
    output logic [CHANNEL_WIDTH-1:0]          min_channel_o,
    output logic [CHANNEL_WIDTH-1:0]          max_channel_o
);

    import axil_pkg::*;

    reg_wr_req_t            wr_req;
    reg_rd_req_t            rd_req;
    logic [AXIL_DATA_W-1:0] rd_data;

    axil_slave_fsm u_axil_slave_fsm (
        .clk            (clk),
        .reset_n        (reset_n),
        .axil_awaddr_i  (axil_awaddr_i),
        .axil_awvalid_i (axil_awvalid_i),
        .axil_awready_o (axil_awready_o),
        .axil_wdata_i   (axil_wdata_i),
        .axil_wstrb_i   (axil_wstrb_i),
        .axil_wvalid_i  (axil_wvalid_i),
        .axil_wready_o  (axil_wready_o),
        .axil_bvalid_o  (axil_bvalid_o),
        .axil_bresp_o   (axil_bresp_o),
        .axil_bready_i  (axil_bready_i),
        .axil_araddr_i  (axil_araddr_i),
        .axil_arvalid_i (axil_arvalid_i),
        .axil_arready_o (axil_arready_o),
        .axil_rvalid_o  (axil_rvalid_o),
        .axil_rdata_o   (axil_rdata_o),
        .axil_rresp_o   (axil_rresp_o),
        .axil_rready_i  (axil_rready_i),
        .wr_req_o       (wr_req),
        .rd_req_o       (rd_req),
        .rd_data_i      (rd_data)
    );

    gen_reg_file #(
        .CHANNEL_WIDTH (CHANNEL_WIDTH)
    ) u_gen_reg_file (
        .clk             (clk),
        .reset_n         (reset_n),
        .wr_req_i        (wr_req),
        .rd_req_i        (rd_req),
        .rd_data_o       (rd_data),
        .start_o         (start_o),
        .stop_o          (stop_o),
        .cfg_o           (cfg_o),
        .fixed_channel_o (fixed_channel_o),
        .min_channel_o   (min_channel_o),
        .max_channel_o   (max_channel_o)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the traffic generator config testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_traffic_gen_cfg -f list.f \
    || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_traffic_gen_cfg 2>&1)"
echo "$sim_out"
grep -qx "all tests passed" <<< "$sim_out" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

//--- verification/tb_axil_tasks.svh
//////////////////////////////
// axi4-lite master tasks and
// random source for the testbench
//////////////////////////////
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

logic [31:0] lcg_state = 32'd35;

// linear congruential generator
function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// upper bits are the better mixed ones
function automatic int unsigned random_below(input int unsigned n);
    return (next_random() >> 16) % n;
endfunction

// completes a read left waiting on arvalid, data not used
task automatic drain_read();
    @(negedge clk);
    while (!axil_arready_o) begin
        @(negedge clk);
    end
    @(posedge clk);
    axil_arvalid_i <= 1'b0;
    axil_rready_i  <= 1'b1;
    @(negedge clk);
    while (!axil_rvalid_o) begin
        @(negedge clk);
    end
    @(posedge clk);
    axil_rready_i <= 1'b0;
endtask

// one write, bready held low for stall cycles of bvalid
task automatic bus_write(
    input  logic [AXIL_ADDR_W-1:0] addr,
    input  logic [AXIL_DATA_W-1:0] data,
    input  logic [AXIL_STRB_W-1:0] strb,
    input  int unsigned            stall,
    output logic                   start_seen,
    output logic                   stop_seen
);
    int unsigned wait_cycles;
    wait_cycles = 0;
    @(posedge clk);
    axil_awaddr_i  <= addr;
    axil_awvalid_i <= 1'b1;
    axil_wdata_i   <= data;
    axil_wstrb_i   <= strb;
    axil_wvalid_i  <= 1'b1;
    // both valids are visible from here on
    @(negedge clk);
    while (!axil_awready_o) begin
        @(negedge clk);
        wait_cycles++;
    end
    check_value("axil_wready_o", 32'd1, 32'(axil_wready_o));
    @(posedge clk);
    axil_awvalid_i <= 1'b0;
    axil_wvalid_i  <= 1'b0;
    @(negedge clk);
    wait_cycles++;
    while (!axil_bvalid_o) begin
        @(negedge clk);
        wait_cycles++;
    end
    check_value("bvalid latency", 32'd2, wait_cycles);
    // pulses belong to the first bvalid cycle
    start_seen = start_o;
    stop_seen  = stop_o;
    @(posedge clk);
    // a read waits behind the stalled write response
    axil_araddr_i  <= addr;
    axil_arvalid_i <= 1'b1;
    repeat (stall) @(posedge clk);
    axil_bready_i <= 1'b1;
    @(posedge clk);
    axil_bready_i <= 1'b0;
    drain_read();
endtask

// one read, rready held low for stall cycles of rvalid
task automatic bus_read(
    input  logic [AXIL_ADDR_W-1:0] addr,
    input  int unsigned            stall,
    output logic [AXIL_DATA_W-1:0] data
);
    int unsigned wait_cycles;
    wait_cycles = 0;
    @(posedge clk);
    axil_araddr_i  <= addr;
    axil_arvalid_i <= 1'b1;
    @(negedge clk);
    while (!axil_arready_o) begin
        @(negedge clk);
        wait_cycles++;
    end
    @(posedge clk);
    axil_arvalid_i <= 1'b0;
    @(negedge clk);
    wait_cycles++;
    while (!axil_rvalid_o) begin
        @(negedge clk);
        wait_cycles++;
    end
    check_value("rvalid latency", 32'd2, wait_cycles);
    data = axil_rdata_o;
    @(posedge clk);
    // another word is requested while the response is stalled
    axil_araddr_i  <= ~addr;
    axil_arvalid_i <= 1'b1;
    repeat (stall) @(posedge clk);
    axil_rready_i <= 1'b1;
    @(posedge clk);
    axil_rready_i <= 1'b0;
    drain_read();
endtask

`endif

//--- verification/tb_traffic_gen_cfg.sv
//////////////////////////////
// testbench for the traffic generator
// config block over axi4-lite
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_traffic_gen_cfg;

    import axil_pkg::*;
    import gen_regs_pkg::*;

    localparam int unsigned CHANNEL_WIDTH  = 10;
    localparam int unsigned FULL_ROUNDS    = 8;
    localparam int unsigned PARTIAL_WRITES = 40;
    // a checked write is a write and a read of at most 17 cycles each
    localparam int unsigned NUM_TXN    = 2 * (FULL_ROUNDS * 11 + PARTIAL_WRITES + 9);
    localparam int unsigned MAX_CYCLES = NUM_TXN * 17 + 1500;

    logic                     clk = 1'b0;
    logic                     reset_n;
    logic [AXIL_ADDR_W-1:0]   axil_awaddr_i;
    logic [AXIL_ADDR_W-1:0]   axil_araddr_i;
    logic [AXIL_DATA_W-1:0]   axil_wdata_i;
    logic [AXIL_STRB_W-1:0]   axil_wstrb_i;
    logic                     axil_awvalid_i, axil_wvalid_i, axil_bready_i;
    logic                     axil_arvalid_i, axil_rready_i;
    logic                     axil_awready_o, axil_wready_o, axil_bvalid_o;
    logic                     axil_arready_o, axil_rvalid_o;
    logic [AXIL_DATA_W-1:0]   axil_rdata_o;
    axil_resp_e               axil_bresp_o;
    axil_resp_e               axil_rresp_o;
    logic                     start_o, stop_o;
    gen_cfg_t                 cfg_o;
    logic [CHANNEL_WIDTH-1:0] fixed_channel_o, min_channel_o, max_channel_o;

    // expected read-back value of every word index
    logic [31:0]              shadow [0:15];
    int unsigned              cycle_count = 0;

    traffic_gen_cfg_top #(
        .CHANNEL_WIDTH (CHANNEL_WIDTH)
    ) DUT (.*);

    always #2 clk = ~clk;

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic protocol_error(input string what);
        $display("error at t=%0t: %s", $time, what);
        stop_on_failure();
    endtask

    `include "tb_axil_tasks.svh"

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout after %0d cycles, a handshake never completed", MAX_CYCLES);
            stop_on_failure();
        end
    end

    // responses hold until the master takes them
    assert property (@(posedge clk) disable iff (!reset_n)
        axil_bvalid_o && !axil_bready_i |=> axil_bvalid_o && $stable(axil_bresp_o))
        else protocol_error("bvalid or bresp changed before bready");
    assert property (@(posedge clk) disable iff (!reset_n)
        axil_rvalid_o && !axil_rready_i
            |=> axil_rvalid_o && $stable(axil_rdata_o) && $stable(axil_rresp_o))
        else protocol_error("rvalid, rdata or rresp changed before rready");
    // no new address while a response waits
    assert property (@(posedge clk) disable iff (!reset_n)
        axil_bvalid_o || axil_rvalid_o
            |-> !(axil_awready_o || axil_wready_o || axil_arready_o))
        else protocol_error("an address was accepted while a response was pending");
    assert property (@(posedge clk) disable iff (!reset_n)
        !(axil_bvalid_o && axil_bresp_o != OKAY) && !(axil_rvalid_o && axil_rresp_o != OKAY))
        else protocol_error("a response other than OKAY was returned");
    // start and stop only in the first bvalid cycle, one cycle wide
    assert property (@(posedge clk) disable iff (!reset_n)
        start_o || stop_o |-> $rose(axil_bvalid_o))
        else protocol_error("start_o or stop_o outside the first bvalid cycle");
    assert property (@(posedge clk) disable iff (!reset_n)
        start_o || stop_o |=> !(start_o || stop_o))
        else protocol_error("start_o or stop_o high for more than one cycle");

    // bits that a word keeps, zero for unmapped words
    function automatic logic [31:0] field_mask(input logic [3:0] idx);
        if (idx == 4'd0) return 32'h0000_003C;
        if (idx <= 4'd3) return 32'h0000_FFFF;
        if (idx <= 4'd6) return (32'd1 << CHANNEL_WIDTH) - 32'd1;
        if (idx <= 4'd10) return 32'hFFFF_FFFF;
        return 32'h0;
    endfunction

    task automatic model_write(input logic [3:0] idx, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] merged;
        merged = shadow[idx];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow[idx] = merged & field_mask(idx);
    endtask

    task automatic check_outputs();
        check_value("cfg_o.mode", {28'd0, shadow[0][2], shadow[0][3], shadow[0][4],
                    shadow[0][5]}, {28'd0, cfg_o.mode});
        check_value("cfg_o.fixed_length", shadow[1], {16'd0, cfg_o.fixed_length});
        check_value("cfg_o.min_length", shadow[2], {16'd0, cfg_o.min_length});
        check_value("cfg_o.max_length", shadow[3], {16'd0, cfg_o.max_length});
        check_value("fixed_channel_o", shadow[4], 32'(fixed_channel_o));
        check_value("min_channel_o", shadow[5], 32'(min_channel_o));
        check_value("max_channel_o", shadow[6], 32'(max_channel_o));
        check_value("cfg_o.fixed_pause", shadow[7], cfg_o.fixed_pause);
        check_value("cfg_o.min_pause", shadow[8], cfg_o.min_pause);
        check_value("cfg_o.max_pause", shadow[9], cfg_o.max_pause);
        check_value("cfg_o.cnt_packet", shadow[10], cfg_o.cnt_packet);
    endtask

    // write, check pulses and outputs, then read the word back
    task automatic write_and_check(input logic [3:0] idx, input logic [31:0] data,
                                   input logic [3:0] strb);
        logic        start_seen;
        logic        stop_seen;
        logic        exp_start;
        logic        exp_stop;
        logic [31:0] rdata;
        exp_start = (idx == 4'd0) && strb[0] && data[0];
        exp_stop  = (idx == 4'd0) && strb[0] && data[1];
        bus_write({idx, 2'b00}, data, strb, random_below(9), start_seen, stop_seen);
        model_write(idx, data, strb);
        check_value("start_o", 32'(exp_start), 32'(start_seen));
        check_value("stop_o", 32'(exp_stop), 32'(stop_seen));
        @(negedge clk);
        check_outputs();
        bus_read({idx, 2'b00}, random_below(9), rdata);
        check_value("axil_rdata_o", shadow[idx], rdata);
    endtask

    initial begin
        reset_n        <= 1'b0;
        axil_awaddr_i  <= '0;
        axil_awvalid_i <= 1'b0;
        axil_wdata_i   <= '0;
        axil_wstrb_i   <= '0;
        axil_wvalid_i  <= 1'b0;
        axil_bready_i  <= 1'b0;
        axil_araddr_i  <= '0;
        axil_arvalid_i <= 1'b0;
        axil_rready_i  <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 32'h0;
        end
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("axil ready and valid outputs", 32'd0, {27'd0, axil_awready_o,
                    axil_wready_o, axil_arready_o, axil_bvalid_o, axil_rvalid_o});
        check_value("start_o and stop_o", 32'd0, {30'd0, start_o, stop_o});
        check_outputs();

        // full-strobe writes over the whole map
        for (int r = 0; r < FULL_ROUNDS; r++) begin
            for (int i = 0; i <= 10; i++) begin
                write_and_check(4'(i), next_random(), 4'hF);
            end
        end
        for (int n = 0; n < PARTIAL_WRITES; n++) begin
            write_and_check(4'(random_below(11)), next_random(), 4'(random_below(16)));
        end

        // pulses need strobe bit 0, mode bits stay until rewritten
        write_and_check(4'd0, 32'h0000_003F, 4'hF);
        write_and_check(4'd0, 32'h0000_0003, 4'hE);
        write_and_check(4'd0, 32'h0000_0001, 4'h1);
        write_and_check(4'd0, 32'h0000_0016, 4'h1);

        // unmapped words ignore writes and read as zero
        for (int i = 11; i < 16; i++) begin
            write_and_check(4'(i), next_random(), 4'hF);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
